/* flist.f */
+incdir+.
fp_add_pkg.sv
fp_stage_if.sv
fp_unpack_align.sv
fp_stage_buffer.sv
fp_add_round.sv
fp_adder_top.sv
tb_fp_adder.sv

/* fp_add_pkg.sv */
// Shared format constants and types for the pipelined single-precision adder
// Referenced by scoped name from every RTL file and from the testbench

package fp_add_pkg;

    // ========================================
    // Format widths
    // ========================================

    // Biased exponent field
    localparam int EXP_W = 8;

    // Stored fraction, hidden bit excluded
    localparam int FRAC_W = 23;

    // Guard, round and sticky positions below the fraction
    localparam int GRS_W = 3;

    // Hidden bit + fraction + GRS
    localparam int MANT_W = 1 + FRAC_W + GRS_W;

    // All-ones exponent, reserved for infinity and NaN
    localparam int EXP_MAX = (1 << EXP_W) - 1;

    // ========================================
    // Words and constants
    // ========================================

    // Sign, exponent, fraction from msb down
    typedef logic [EXP_W+FRAC_W:0] fp_word_t;

    // Canonical quiet NaN, positive, top fraction bit set
    localparam fp_word_t QNAN = {1'b0, {EXP_W{1'b1}}, 1'b1, {(FRAC_W-1){1'b0}}};

    // ========================================
    // Enumerations
    // ========================================

    // Operand class; subnormals are folded into FP_ZERO
    typedef enum logic [1:0] {
        FP_ZERO,
        FP_NORMAL,
        FP_INF,
        FP_NAN
    } fp_class_e;

    // Which result path the operand pair takes
    typedef enum logic {
        PATH_ARITH,
        PATH_SPECIAL
    } fp_path_e;

    // Effective operation once the signs are compared
    typedef enum logic {
        OP_ADD,
        OP_SUB
    } fp_op_e;

    // Exception flags, registered with the sum
    typedef struct packed {
        logic overflow;
        logic underflow;
        logic inexact;
    } fp_flags_t;

endpackage

/* fp_add_round.sv */
// Second adder stage that adds or subtracts, normalizes and rounds to nearest even
// Result word and flags are registered one cycle after the pair arrives

`timescale 1ns/1ps

module fp_add_round (
    input  logic                  clk,
    input  logic                  rst_n,
    fp_stage_if.consumer          bus,
    output logic                  out_valid,
    output fp_add_pkg::fp_word_t  sum,
    output fp_add_pkg::fp_flags_t flags
);

    // Wide add
    logic [fp_add_pkg::MANT_W:0]            mant_l;
    logic [fp_add_pkg::MANT_W-1:0]          small27;
    logic [fp_add_pkg::MANT_W:0]            sum_raw;

    // Normalize
    logic [4:0]                             lzc;
    logic [fp_add_pkg::MANT_W-1:0]          norm;
    logic signed [fp_add_pkg::EXP_W+1:0]    exp_ext;
    logic signed [fp_add_pkg::EXP_W+1:0]    exp_n;

    // Round
    logic                                   lsb;
    logic                                   guard;
    logic                                   round;
    logic                                   sticky;
    logic                                   round_up;
    logic [fp_add_pkg::FRAC_W+1:0]          mant_rnd;
    logic signed [fp_add_pkg::EXP_W+1:0]    exp_r;
    logic [fp_add_pkg::FRAC_W-1:0]          frac_out;

    // Next registered values
    fp_add_pkg::fp_word_t                   res_word;
    fp_add_pkg::fp_flags_t                  res_flags;

    // ========================================
    // Add or subtract
    // ========================================

    // Fold the extra bottom bit into sticky
    assign small27 = {bus.mant_small[fp_add_pkg::MANT_W:2], |bus.mant_small[1:0]};
    assign mant_l  = {1'b0, bus.mant_large};

    // Larger magnitude first, so subtraction never goes negative
    assign sum_raw = (bus.op == fp_add_pkg::OP_SUB) ? mant_l - {1'b0, small27} :
                                                      mant_l + {1'b0, small27};

    // Leading zeros below the carry bit where the highest set bit wins
    always_comb begin
        lzc = 5'(fp_add_pkg::MANT_W);
        for (int i = 0; i < fp_add_pkg::MANT_W; i++) begin
            if (sum_raw[i])
                lzc = 5'(fp_add_pkg::MANT_W - 1 - i);
        end
    end

    // ========================================
    // Normalize
    // ========================================

    assign exp_ext = {2'b00, bus.exp_large};

    always_comb begin
        if (sum_raw[fp_add_pkg::MANT_W]) begin
            // Carry out shifts right one and keeps the lost bit in sticky
            norm  = {sum_raw[fp_add_pkg::MANT_W:2], sum_raw[1] | sum_raw[0]};
            exp_n = exp_ext + 1;
        end else if (sum_raw[fp_add_pkg::MANT_W-1]) begin
            // Already 1.xxx
            norm  = sum_raw[fp_add_pkg::MANT_W-1:0];
            exp_n = exp_ext;
        end else begin
            // Cancellation
            norm  = sum_raw[fp_add_pkg::MANT_W-1:0] << lzc;
            exp_n = exp_ext - (fp_add_pkg::EXP_W+2)'(lzc);
        end
    end

    // ========================================
    // Round to nearest even
    // ========================================

    assign lsb      = norm[fp_add_pkg::GRS_W];
    assign guard    = norm[2];
    assign round    = norm[1];
    assign sticky   = norm[0];
    assign round_up = guard & (round | sticky | lsb);

    // Spare msb catches the rounding carry
    assign mant_rnd = {1'b0, norm[fp_add_pkg::MANT_W-1:fp_add_pkg::GRS_W]} +
                      (fp_add_pkg::FRAC_W+2)'(round_up);

    // 1.111..1 rounding up to 10.000..0 bumps the exponent
    assign exp_r    = mant_rnd[fp_add_pkg::FRAC_W+1] ? exp_n + 1 : exp_n;

    // Fraction bits are already zero after a rounding carry
    assign frac_out = mant_rnd[fp_add_pkg::FRAC_W-1:0];

    // Final result pick
    always_comb begin
        res_flags = '0;
        if (bus.path == fp_add_pkg::PATH_SPECIAL) begin
            res_word = bus.special_word;
        end else if (sum_raw == '0) begin
            // Exact cancellation is +0
            res_word = '0;
        end else if (exp_r >= fp_add_pkg::EXP_MAX) begin
            res_word           = {bus.sign_large, {fp_add_pkg::EXP_W{1'b1}},
                                  {fp_add_pkg::FRAC_W{1'b0}}};
            res_flags.overflow = 1'b1;
            res_flags.inexact  = 1'b1;
        end else if (exp_r < 1) begin
            // Flush to signed zero
            res_word            = {bus.sign_large, {(fp_add_pkg::EXP_W+fp_add_pkg::FRAC_W){1'b0}}};
            res_flags.underflow = 1'b1;
            res_flags.inexact   = 1'b1;
        end else begin
            res_word          = {bus.sign_large, exp_r[fp_add_pkg::EXP_W-1:0], frac_out};
            res_flags.inexact = guard | round | sticky;
        end
    end

    // ========================================
    // Output register
    // ========================================

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
            sum       <= '0;
            flags     <= '0;
        end else begin
            out_valid <= bus.valid;
            sum       <= res_word;
            flags     <= res_flags;
        end
    end

    // No result without a pair one cycle earlier
    a_out_has_in : assert property (
        @(posedge clk) disable iff (!rst_n) out_valid |-> $past(bus.valid)
    ) else $error("add: out_valid without input");

    // Overflow always leaves an infinity exponent
    a_ovf_inf : assert property (
        @(posedge clk) disable iff (!rst_n)
        flags.overflow |-> (sum[fp_add_pkg::FRAC_W +: fp_add_pkg::EXP_W] == '1)
    ) else $error("add: overflow with finite exponent");

endmodule

/* fp_adder_top.sv */
// Two-stage pipelined single-precision adder, top level
// One pair per in_valid strobe, result with out_valid two clocks later

`timescale 1ns/1ps

module fp_adder_top (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  fp_add_pkg::fp_word_t a,
    input  fp_add_pkg::fp_word_t b,
    output logic                 out_valid,
    output fp_add_pkg::fp_word_t sum,
    output logic                 overflow,
    output logic                 underflow,
    output logic                 inexact
);

    // Align stage to pipeline register
    fp_stage_if align_bus ();

    // Pipeline register to add stage
    fp_stage_if add_bus ();

    // Registered flags from the add stage
    fp_add_pkg::fp_flags_t flags;

    // Unpack, classify, align
    fp_unpack_align u_align (
        .a        (a),
        .b        (b),
        .in_valid (in_valid),
        .bus      (align_bus.producer)
    );

    // Stage boundary
    fp_stage_buffer u_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .up    (align_bus.consumer),
        .down  (add_bus.producer)
    );

    // Add, normalize, round, register
    fp_add_round u_add (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus       (add_bus.consumer),
        .out_valid (out_valid),
        .sum       (sum),
        .flags     (flags)
    );

    assign overflow  = flags.overflow;
    assign underflow = flags.underflow;
    assign inexact   = flags.inexact;

endmodule

/* fp_stage_buffer.sv */
// Pipeline register between the align stage and the add stage
// Moves one operand pair per clock, only the valid bit is reset

`timescale 1ns/1ps

module fp_stage_buffer (
    input  logic          clk,
    input  logic          rst_n,
    fp_stage_if.consumer  up,
    fp_stage_if.producer  down
);

    // Valid bit, cleared in reset
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            down.valid <= 1'b0;
        end else begin
            down.valid <= up.valid;
        end
    end

    // Payload loads every cycle, ignored while valid is low
    always_ff @(posedge clk) begin
        down.path         <= up.path;
        down.special_word <= up.special_word;
        down.sign_large   <= up.sign_large;
        down.op           <= up.op;
        down.exp_large    <= up.exp_large;
        down.mant_large   <= up.mant_large;
        down.mant_small   <= up.mant_small;
    end

    // ========================================
    // Checks
    // ========================================

    // Valid is delayed by exactly one cycle once out of reset
    a_valid_delay : assert property (
        @(posedge clk) ($past(rst_n) && rst_n) |-> (down.valid == $past(up.valid))
    ) else $error("buffer: valid not delayed by one cycle");

endmodule

/* fp_stage_if.sv */
// One aligned operand pair as it moves between the adder pipeline stages
// Producer side drives every field, consumer side only reads them

`timescale 1ns/1ps

interface fp_stage_if;

    // Pair is live this cycle
    logic                                 valid;

    // Arithmetic or bypass result
    fp_add_pkg::fp_path_e                 path;

    // Finished word for the bypass path
    fp_add_pkg::fp_word_t                 special_word;

    // Sign and exponent of the larger magnitude operand
    logic                                 sign_large;
    fp_add_pkg::fp_op_e                   op;
    logic [fp_add_pkg::EXP_W-1:0]         exp_large;

    // Hidden bit, fraction and empty GRS slots
    logic [fp_add_pkg::MANT_W-1:0]        mant_large;

    // Shifted smaller mantissa, one extra sticky bit at the bottom
    logic [fp_add_pkg::MANT_W:0]          mant_small;

    modport producer (
        output valid,
        output path,
        output special_word,
        output sign_large,
        output op,
        output exp_large,
        output mant_large,
        output mant_small
    );

    modport consumer (
        input valid,
        input path,
        input special_word,
        input sign_large,
        input op,
        input exp_large,
        input mant_large,
        input mant_small
    );

endinterface

/* fp_unpack_align.sv */
// First adder stage, purely combinational
// Classifies both operands, builds the bypass word and aligns the smaller mantissa

`timescale 1ns/1ps

module fp_unpack_align (
    input  fp_add_pkg::fp_word_t a,
    input  fp_add_pkg::fp_word_t b,
    input  logic                 in_valid,
    fp_stage_if.producer         bus
);

    // Field split of both operands
    logic                              sign_a;
    logic                              sign_b;
    logic [fp_add_pkg::EXP_W-1:0]      exp_a;
    logic [fp_add_pkg::EXP_W-1:0]      exp_b;
    logic [fp_add_pkg::FRAC_W-1:0]     frac_a;
    logic [fp_add_pkg::FRAC_W-1:0]     frac_b;
    fp_add_pkg::fp_class_e             class_a;
    fp_add_pkg::fp_class_e             class_b;

    // Bypass decode
    logic                              nan_res;
    fp_add_pkg::fp_path_e              path;
    fp_add_pkg::fp_word_t              special_word;

    // Alignment datapath
    logic                              a_larger;
    logic [fp_add_pkg::EXP_W-1:0]      exp_large;
    logic [fp_add_pkg::EXP_W-1:0]      exp_small;
    logic [fp_add_pkg::EXP_W-1:0]      exp_diff;
    logic [fp_add_pkg::FRAC_W-1:0]     frac_large;
    logic [fp_add_pkg::FRAC_W-1:0]     frac_small;
    logic [fp_add_pkg::MANT_W:0]       small_field;
    logic [fp_add_pkg::MANT_W:0]       small_kept;
    logic [fp_add_pkg::MANT_W:0]       small_lost;

    // Zero exponent means zero, subnormals included
    function automatic fp_add_pkg::fp_class_e classify(input fp_add_pkg::fp_word_t w);
        logic [fp_add_pkg::EXP_W-1:0]  e;
        logic [fp_add_pkg::FRAC_W-1:0] f;
        e = w[fp_add_pkg::FRAC_W +: fp_add_pkg::EXP_W];
        f = w[fp_add_pkg::FRAC_W-1:0];
        if (e == '0)
            return fp_add_pkg::FP_ZERO;
        else if (e == '1)
            return (f == '0) ? fp_add_pkg::FP_INF : fp_add_pkg::FP_NAN;
        else
            return fp_add_pkg::FP_NORMAL;
    endfunction

    assign sign_a  = a[fp_add_pkg::EXP_W+fp_add_pkg::FRAC_W];
    assign sign_b  = b[fp_add_pkg::EXP_W+fp_add_pkg::FRAC_W];
    assign exp_a   = a[fp_add_pkg::FRAC_W +: fp_add_pkg::EXP_W];
    assign exp_b   = b[fp_add_pkg::FRAC_W +: fp_add_pkg::EXP_W];
    assign frac_a  = a[fp_add_pkg::FRAC_W-1:0];
    assign frac_b  = b[fp_add_pkg::FRAC_W-1:0];
    assign class_a = classify(a);
    assign class_b = classify(b);

    // ========================================
    // Special case bypass
    // ========================================

    always_comb begin
        // NaN in, or inf - inf
        nan_res = (class_a == fp_add_pkg::FP_NAN) || (class_b == fp_add_pkg::FP_NAN) ||
                  (class_a == fp_add_pkg::FP_INF && class_b == fp_add_pkg::FP_INF &&
                   sign_a != sign_b);
        if (nan_res)
            special_word = fp_add_pkg::QNAN;
        else if (class_a == fp_add_pkg::FP_INF)
            special_word = a;
        else if (class_b == fp_add_pkg::FP_INF)
            special_word = b;
        else if (class_a == fp_add_pkg::FP_ZERO && class_b == fp_add_pkg::FP_ZERO)
            // -0 only when both are negative
            special_word = {sign_a & sign_b, {(fp_add_pkg::EXP_W+fp_add_pkg::FRAC_W){1'b0}}};
        else if (class_a == fp_add_pkg::FP_ZERO)
            special_word = b;
        else
            special_word = a;
    end

    assign path = (class_a != fp_add_pkg::FP_NORMAL || class_b != fp_add_pkg::FP_NORMAL) ?
                  fp_add_pkg::PATH_SPECIAL : fp_add_pkg::PATH_ARITH;

    // ========================================
    // Magnitude order and alignment
    // ========================================

    // Exponent then fraction, both normal here
    assign a_larger   = (a[fp_add_pkg::EXP_W+fp_add_pkg::FRAC_W-1:0] >=
                         b[fp_add_pkg::EXP_W+fp_add_pkg::FRAC_W-1:0]);
    assign exp_large  = a_larger ? exp_a : exp_b;
    assign exp_small  = a_larger ? exp_b : exp_a;
    assign frac_large = a_larger ? frac_a : frac_b;
    assign frac_small = a_larger ? frac_b : frac_a;
    assign exp_diff   = exp_large - exp_small;

    // Hidden one, fraction, GRS and the extra sticky slot
    assign small_field = {1'b1, frac_small, {(fp_add_pkg::GRS_W+1){1'b0}}};

    always_comb begin
        if (exp_diff > fp_add_pkg::MANT_W) begin
            // Everything falls off, only sticky survives
            small_kept = '0;
            small_lost = small_field;
        end else begin
            small_kept = small_field >> exp_diff;
            small_lost = small_field << (fp_add_pkg::MANT_W + 1 - exp_diff);
        end
    end

    assign bus.valid        = in_valid;
    assign bus.path         = path;
    assign bus.special_word = special_word;
    assign bus.sign_large   = a_larger ? sign_a : sign_b;
    assign bus.op           = (sign_a != sign_b) ? fp_add_pkg::OP_SUB : fp_add_pkg::OP_ADD;
    assign bus.exp_large    = exp_large;
    assign bus.mant_large   = {1'b1, frac_large, {fp_add_pkg::GRS_W{1'b0}}};
    assign bus.mant_small   = small_kept | {{fp_add_pkg::MANT_W{1'b0}}, |small_lost};

    // Larger operand really has the larger exponent
    always_comb begin
        if (in_valid && path == fp_add_pkg::PATH_ARITH) begin
            assert final (exp_large >= exp_a && exp_large >= exp_b)
                else $error("align: exp_large below an operand exponent");
        end
    end

endmodule

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the adder testbench with Verilator, verdict taken from the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module tb_fp_adder \
    -f flist.f -o sim_fp_adder

./obj_dir/sim_fp_adder | tee sim.log

if grep -q "^Test completed successfully$" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation did not pass, see sim.log"
    exit 1
fi

/* tb_fp_ref.svh */
// Reference model for the adder testbench, exact arithmetic on wide integers
// Included inside the testbench module, rounds once from the exact sum

// Word from sign, biased exponent and fraction
function automatic fp_add_pkg::fp_word_t pack_word(input logic s, input int e, input int f);
    return {s, e[7:0], f[22:0]};
endfunction

// Expected sum and flags of one operand pair
function automatic fp_add_pkg::fp_word_t fp_add_ref(input fp_add_pkg::fp_word_t x,
        input fp_add_pkg::fp_word_t y, output fp_add_pkg::fp_flags_t flags);
    logic [287:0] big_x, big_y, total, kept, rem, half;
    int           ex, ey, es, msb, shift, e_res;
    logic         s_res, inf_x, inf_y, nan_res;
    flags   = '0;
    ex      = x[30:23];
    ey      = y[30:23];
    inf_x   = (ex == 255) && (x[22:0] == 0);
    inf_y   = (ey == 255) && (y[22:0] == 0);
    nan_res = (ex == 255 && !inf_x) || (ey == 255 && !inf_y) ||
              (inf_x && inf_y && x[31] != y[31]);
    // Bypass cases, a zero exponent counts as zero
    if (nan_res) return fp_add_pkg::QNAN;
    if (inf_x) return x;
    if (inf_y) return y;
    if (ex == 0 && ey == 0) return pack_word(x[31] & y[31], 0, 0);
    if (ex == 0) return y;
    if (ey == 0) return x;
    // Both mantissas on a common scale of 2^(es - 150)
    es    = (ex < ey) ? ex : ey;
    big_x = {264'd0, 1'b1, x[22:0]} << (ex - es);
    big_y = {264'd0, 1'b1, y[22:0]} << (ey - es);
    s_res = (big_x >= big_y) ? x[31] : y[31];
    if (x[31] == y[31]) total = big_x + big_y;
    else if (big_x >= big_y) total = big_x - big_y;
    else total = big_y - big_x;
    if (total == 0) return '0;
    msb = 0;
    for (int i = 0; i < 288; i++) begin
        if (total[i]) msb = i;
    end
    e_res = es + msb - 23;
    if (msb > 23) begin
        // Nearest even on everything below the 24 kept bits
        shift = msb - 23;
        kept  = total >> shift;
        rem   = total & ((288'd1 << shift) - 1);
        half  = 288'd1 << (shift - 1);
        flags.inexact = (rem != 0);
        if (rem > half || (rem == half && kept[0])) kept = kept + 1;
    end else begin
        kept = total << (23 - msb);
    end
    if (kept[24]) begin
        kept  = kept >> 1;
        e_res = e_res + 1;
    end
    if (e_res >= 255) begin
        flags.overflow = 1'b1;
        flags.inexact  = 1'b1;
        return pack_word(s_res, 255, 0);
    end
    if (e_res < 1) begin
        flags.underflow = 1'b1;
        flags.inexact   = 1'b1;
        return pack_word(s_res, 0, 0);
    end
    return pack_word(s_res, e_res, kept[22:0]);
endfunction

/* tb_fp_adder.sv */
// Testbench for the two-stage single-precision adder
// Issues pairs on the falling edge and checks sum, flags and latency against the reference

`timescale 1ns/1ps

module tb_fp_adder;

    logic                  clk = 1'b0;
    logic                  rst_n;
    logic                  in_valid;
    fp_add_pkg::fp_word_t  a;
    fp_add_pkg::fp_word_t  b;
    logic                  out_valid;
    fp_add_pkg::fp_word_t  sum;
    logic                  overflow;
    logic                  underflow;
    logic                  inexact;
    fp_add_pkg::fp_flags_t got_flags;

    // Expected results in issue order along with the cycle of issue
    fp_add_pkg::fp_word_t  want_word[$];
    fp_add_pkg::fp_flags_t want_flags[$];
    int                    want_cycle[$];

    integer seed      = 32'h73be477f;
    int     cycle     = 0;
    int     errors    = 0;
    int     tests_ok  = 0;
    int     tests_bad = 0;
    logic   timed_out = 1'b0;
    string  names[6]  = '{"special", "zero", "exact", "random", "range", "stream"};

    `include "tb_fp_ref.svh"

    fp_adder_top dut (.*);

    assign got_flags = {overflow, underflow, inexact};

    always #50 clk = ~clk;

    // Cycle count read on the falling edge for latency
    always @(posedge clk) cycle <= cycle + 1;

    task automatic check_word(input fp_add_pkg::fp_word_t got, input fp_add_pkg::fp_word_t want);
        if (got !== want) begin
            $display("[ERROR] %0t ns: sum %08h, expected %08h", $time, got, want);
            errors++;
        end
    endtask

    task automatic check_flags(input fp_add_pkg::fp_flags_t got,
                               input fp_add_pkg::fp_flags_t want);
        if (got !== want) begin
            $display("[ERROR] %0t ns: flags ovf/unf/inx %03b, expected %03b", $time, got, want);
            errors++;
        end
    endtask

    // One pair on the falling edge and an idle cycle after it when gap is set
    task automatic issue(input fp_add_pkg::fp_word_t x, input fp_add_pkg::fp_word_t y,
                         input bit gap);
        fp_add_pkg::fp_flags_t f;
        @(negedge clk);
        in_valid = 1'b1;
        a        = x;
        b        = y;
        want_word.push_back(fp_add_ref(x, y, f));
        want_flags.push_back(f);
        want_cycle.push_back(cycle);
        if (gap) begin
            @(negedge clk);
            in_valid = 1'b0;
        end
    endtask

    function automatic fp_add_pkg::fp_word_t rand_normal();
        return pack_word($random(seed), 1 + {$random(seed)} % 254, $random(seed));
    endfunction

    // Exponent within 27 of x, so alignment keeps some overlap
    function automatic fp_add_pkg::fp_word_t rand_near(input fp_add_pkg::fp_word_t x);
        int e;
        e = x[30:23];
        e = e + $random(seed) % 28;
        if (e < 1) e = 1;
        if (e > 254) e = 254;
        return pack_word($random(seed), e, $random(seed));
    endfunction

    // Drain the pipeline with a timeout, then report the test
    task automatic finish_test(input string name, input int base);
        int waited;
        waited = 0;
        @(negedge clk);
        in_valid = 1'b0;
        while (want_word.size() != 0 && waited < 20) begin
            @(negedge clk);
            waited++;
        end
        if (want_word.size() != 0) begin
            $display("Timeout: %0d results of test %s never came out", want_word.size(), name);
            timed_out = 1'b1;
        end
        if (errors == base && !timed_out) begin
            tests_ok++;
            $display("test %-8s ok", name);
        end else begin
            tests_bad++;
            $display("test %-8s FAILED, %0d errors", name, errors - base);
        end
    endtask

    // ========================================
    // Result compare on the falling edge where outputs are stable
    // ========================================

    always @(negedge clk) begin
        int lat;
        if (rst_n && out_valid) begin
            if (want_word.size() == 0) begin
                $display("Unexpected result at %0t ns, no pair was outstanding", $time);
                errors++;
            end else begin
                check_word(sum, want_word.pop_front());
                check_flags(got_flags, want_flags.pop_front());
                lat = cycle - want_cycle.pop_front();
                if (lat != 2) begin
                    $display("[ERROR] %0t ns: latency %0d cycles, expected 2", $time, lat);
                    errors++;
                end
            end
        end
    end

    // ========================================
    // Test sequence
    // ========================================

    initial begin
        fp_add_pkg::fp_word_t x;
        int                   base;
        rst_n    = 1'b0;
        in_valid = 1'b0;
        a        = '0;
        b        = '0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        // Output register comes out of reset cleared
        if (out_valid !== 1'b0) begin
            $display("[ERROR] %0t ns: out_valid %b after reset, expected 0", $time, out_valid);
            errors++;
        end
        check_word(sum, '0);
        check_flags(got_flags, '0);
        for (int t = 0; t < 6 && !timed_out; t++) begin
            base = errors;
            case (t)
                0: begin
                    // NaN in, inf - inf, inf + finite
                    issue(32'h7fc00000, 32'h3f800000, 1);
                    issue(32'h40000000, 32'hff812345, 1);
                    issue(32'h7f800000, 32'hff800000, 1);
                    issue(32'h7f800000, 32'h7fc00001, 1);
                    issue(32'h7f800000, 32'hc2f60000, 1);
                    issue(32'h40400000, 32'hff800000, 1);
                end
                1: begin
                    // Signed zeros, zero + x, subnormals taken as zero
                    issue(32'h00000000, 32'h80000000, 1);
                    issue(32'h80000000, 32'h80000000, 1);
                    issue(32'h00000000, 32'h40490fdb, 1);
                    issue(32'hc1200000, 32'h80000000, 1);
                    issue(32'h00123456, 32'h3f800000, 1);
                    issue(32'h80000001, 32'h80400000, 1);
                    issue(32'h00400000, 32'h80000000, 1);
                end
                2: begin
                    // 1+1, 1.5+2.5, 3-1, 0.75-1, x-x, -100+100
                    issue(32'h3f800000, 32'h3f800000, 1);
                    issue(32'h3fc00000, 32'h40200000, 1);
                    issue(32'h40400000, 32'hbf800000, 1);
                    issue(32'h3f400000, 32'hbf800000, 1);
                    issue(32'h40490fdb, 32'hc0490fdb, 1);
                    issue(32'hc2c80000, 32'h42c80000, 1);
                end
                3: begin
                    for (int i = 0; i < 300; i++) begin
                        x = rand_normal();
                        issue(x, rand_near(x), 0);
                    end
                end
                4: begin
                    // Overflow to signed inf and tiny differences flushed
                    issue(32'h7f7fffff, 32'h7f7fffff, 1);
                    issue(32'hff7fffff, 32'hff000000, 1);
                    issue(32'h7f000000, 32'h7f000000, 1);
                    issue(32'h00800001, 32'h80800000, 1);
                    issue(32'h80c00000, 32'h00800000, 1);
                end
                default: begin
                    // Back to back with bypass pairs mixed in
                    for (int i = 0; i < 24; i++) begin
                        x = rand_normal();
                        issue((i % 4 == 0) ? 32'h7f800000 : x, rand_near(x), 0);
                    end
                end
            endcase
            finish_test(names[t], base);
        end
        $display("Summary: %0d tests passed, %0d tests with errors", tests_ok, tests_bad);
        if (errors == 0 && !timed_out)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule
